// ==== Bender.yml ====
package:
  name: llc

sources:
  - hdl/llc_geom_pkg.sv
  - hdl/llc_msg_pkg.sv
  - hdl/llc_chan_buf.sv
  - hdl/llc_tag_store.sv
  - hdl/llc_line_store.sv
  - hdl/llc_ctrl.sv
  - hdl/llc_top.sv
  - target: test
    files:
      - tb/llc_tb.sv

// ==== hdl/llc_chan_buf.sv ====
`timescale 1ns/1ps

module llc_chan_buf #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    input  logic     take_i,
    output logic     full_o,
    output payload_t data_o
);

    // Accept only while empty
    assign ready_o = !full_o;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full_o <= 1'b0;
        end else if (valid_i && ready_o) begin
            full_o <= 1'b1;
        end else if (take_i) begin
            full_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && ready_o) begin
            data_o <= data_i;
        end
    end

    // Controller pops only a held payload
    take_needs_full: assert property (
        @(posedge clk) disable iff (!rst) take_i |-> full_o
    );

endmodule

// ==== hdl/llc_ctrl.sv ====
`timescale 1ns/1ps

module llc_ctrl #(
    parameter int WAYS = llc_geom_pkg::DEF_WAYS,
    parameter int SETS = llc_geom_pkg::DEF_SETS,
    localparam int SET_BITS = $clog2(SETS),
    localparam int TAG_BITS = llc_geom_pkg::ADDR_BITS - SET_BITS,
    localparam int WAY_BITS = $clog2(WAYS)
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_full_i,
    input  llc_msg_pkg::req_t               req_data_i,
    output logic                            req_take_o,
    input  logic                            mrsp_full_i,
    input  llc_msg_pkg::mem_rsp_t           mrsp_data_i,
    output logic                            mrsp_take_o,
    output logic [SET_BITS-1:0]             set_o,
    input  logic [TAG_BITS-1:0]             tags_i [WAYS],
    input  logic [WAYS-1:0]                 way_valid_i,
    input  logic [WAYS-1:0]                 way_dirty_i,
    input  logic [WAY_BITS-1:0]             evict_way_i,
    input  llc_geom_pkg::line_t             lines_i [WAYS],
    output logic [WAY_BITS-1:0]             wr_way_o,
    output logic                            tag_wr_en_o,
    output logic [TAG_BITS-1:0]             tag_wr_tag_o,
    output logic                            tag_wr_dirty_o,
    output logic                            adv_evict_o,
    output logic                            line_wr_en_o,
    output llc_geom_pkg::line_t             wr_line_o,
    output logic                            mem_req_valid_o,
    input  logic                            mem_req_ready_i,
    output logic                            mem_req_write_o,
    output llc_geom_pkg::line_addr_t        mem_req_addr_o,
    output llc_geom_pkg::line_t             mem_req_line_o,
    output logic                            rsp_valid_o,
    input  logic                            rsp_ready_i,
    output logic [llc_msg_pkg::ID_BITS-1:0] rsp_id_o,
    output llc_geom_pkg::line_t             rsp_line_o,
    output logic                            rsp_hit_o
);

    llc_msg_pkg::ctrl_state_e state, next_state;
    llc_msg_pkg::req_t        req_q;

    logic [TAG_BITS-1:0]      tags_buf [WAYS];
    logic [WAYS-1:0]          valid_buf;
    logic [WAYS-1:0]          dirty_buf;
    llc_geom_pkg::line_t      lines_buf [WAYS];
    logic [WAY_BITS-1:0]      evict_buf;

    logic [TAG_BITS-1:0]      req_tag;
    logic                     hit;
    logic [WAY_BITS-1:0]      hit_way;
    logic                     hit_q;
    logic                     dirty_q;
    logic [WAY_BITS-1:0]      way_q;
    llc_geom_pkg::line_t      line_q;
    llc_geom_pkg::line_addr_t wb_addr_q;
    logic                     wb_pend;
    logic                     rd_pend;
    logic                     fill_wait;
    logic                     process_done;
    logic                     mem_fire;

    assign set_o   = req_q.addr[SET_BITS-1:0];
    assign req_tag = req_q.addr[llc_geom_pkg::ADDR_BITS-1:SET_BITS];

    //##################################################
    // Sequencing
    //##################################################

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= llc_msg_pkg::DECODE;
        end else begin
            state <= next_state;
        end
    end

    assign process_done = !wb_pend && !rd_pend && !fill_wait;

    always_comb begin
        next_state = state;
        case (state)
            llc_msg_pkg::DECODE:
                if (req_full_i) begin
                    next_state = llc_msg_pkg::READ_SET;
                end
            llc_msg_pkg::READ_SET: next_state = llc_msg_pkg::WAIT;
            llc_msg_pkg::WAIT:     next_state = llc_msg_pkg::LOOKUP;
            llc_msg_pkg::LOOKUP:   next_state = llc_msg_pkg::PROCESS;
            llc_msg_pkg::PROCESS:
                if (process_done) begin
                    next_state = llc_msg_pkg::UPDATE;
                end
            llc_msg_pkg::UPDATE:   next_state = llc_msg_pkg::RESPOND;
            llc_msg_pkg::RESPOND:
                if (rsp_ready_i) begin
                    next_state = llc_msg_pkg::DECODE;
                end
            default:               next_state = llc_msg_pkg::DECODE;
        endcase
    end

    assign req_take_o = (state == llc_msg_pkg::DECODE) && req_full_i;

    always_ff @(posedge clk) begin
        if (req_take_o) begin
            req_q <= req_data_i;
        end
    end

    // Snapshot of the set once the stores answer
    always_ff @(posedge clk) begin
        if (state == llc_msg_pkg::WAIT) begin
            tags_buf  <= tags_i;
            valid_buf <= way_valid_i;
            dirty_buf <= way_dirty_i;
            lines_buf <= lines_i;
            evict_buf <= evict_way_i;
        end
    end

    //##################################################
    // Lookup and victim selection
    //##################################################

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < WAYS; i++) begin
            if (valid_buf[i] && tags_buf[i] == req_tag) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == llc_msg_pkg::LOOKUP) begin
            way_q     <= hit ? hit_way : evict_buf;
            line_q    <= hit ? lines_buf[hit_way] : lines_buf[evict_buf];
            dirty_q   <= hit && dirty_buf[hit_way];
            wb_addr_q <= {tags_buf[evict_buf], set_o};
        end else if (mrsp_take_o) begin
            line_q <= mrsp_data_i.line;
        end
    end

    // Writeback first, then the fill read
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hit_q     <= 1'b0;
            wb_pend   <= 1'b0;
            rd_pend   <= 1'b0;
            fill_wait <= 1'b0;
        end else if (state == llc_msg_pkg::LOOKUP) begin
            hit_q   <= hit;
            wb_pend <= !hit && valid_buf[evict_buf] && dirty_buf[evict_buf];
            rd_pend <= !hit && !req_q.write;
        end else begin
            if (mem_fire) begin
                if (wb_pend) begin
                    wb_pend <= 1'b0;
                end else begin
                    rd_pend   <= 1'b0;
                    fill_wait <= 1'b1;
                end
            end
            if (mrsp_take_o) begin
                fill_wait <= 1'b0;
            end
        end
    end

    assign mem_req_valid_o = (state == llc_msg_pkg::PROCESS) && (wb_pend || rd_pend);
    assign mem_fire        = mem_req_valid_o && mem_req_ready_i;
    assign mem_req_write_o = wb_pend;
    assign mem_req_addr_o  = wb_pend ? wb_addr_q : req_q.addr;
    assign mem_req_line_o  = line_q;
    assign mrsp_take_o     = (state == llc_msg_pkg::PROCESS) && fill_wait && mrsp_full_i;

    //##################################################
    // Update and response
    //##################################################

    assign wr_way_o       = way_q;
    assign tag_wr_en_o    = (state == llc_msg_pkg::UPDATE);
    assign tag_wr_tag_o   = req_tag;
    assign tag_wr_dirty_o = dirty_q || req_q.write;
    assign adv_evict_o    = (state == llc_msg_pkg::UPDATE) && !hit_q;
    // A read hit leaves the line as it is
    assign line_wr_en_o   = (state == llc_msg_pkg::UPDATE) && (req_q.write || !hit_q);
    assign wr_line_o      = req_q.write ? req_q.line : line_q;

    assign rsp_valid_o = (state == llc_msg_pkg::RESPOND);
    assign rsp_id_o    = req_q.id;
    assign rsp_line_o  = wr_line_o;
    assign rsp_hit_o   = hit_q;

    mem_req_hold: assert property (
        @(posedge clk) disable iff (!rst)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o
            && $stable(mem_req_write_o) && $stable(mem_req_addr_o)
            && $stable(mem_req_line_o)
    );

endmodule

// ==== hdl/llc_geom_pkg.sv ====
package llc_geom_pkg;

    //##################################################
    // Address and line geometry
    //##################################################

    // Width of a line address
    localparam int ADDR_BITS = 16;

    // One cache line
    localparam int LINE_BITS = 64;

    // Default organisation that the top level can override
    localparam int DEF_WAYS = 4;
    localparam int DEF_SETS = 16;

    typedef logic [ADDR_BITS-1:0] line_addr_t;
    typedef logic [LINE_BITS-1:0] line_t;

endpackage

// ==== hdl/llc_line_store.sv ====
`timescale 1ns/1ps

module llc_line_store #(
    parameter int WAYS = llc_geom_pkg::DEF_WAYS,
    parameter int SETS = llc_geom_pkg::DEF_SETS,
    localparam int SET_BITS = $clog2(SETS),
    localparam int WAY_BITS = $clog2(WAYS)
) (
    input  logic                clk,
    input  logic [SET_BITS-1:0] set_i,
    output llc_geom_pkg::line_t lines_o [WAYS],
    input  logic                wr_en_i,
    input  logic [WAY_BITS-1:0] wr_way_i,
    input  llc_geom_pkg::line_t wr_line_i
);

    llc_geom_pkg::line_t line_mem [SETS][WAYS];

    // Whole set out one cycle after the index
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            line_mem[set_i][wr_way_i] <= wr_line_i;
        end
        lines_o <= line_mem[set_i];
    end

endmodule

// ==== hdl/llc_msg_pkg.sv ====
package llc_msg_pkg;

    //##################################################
    // Channel payloads
    //##################################################

    // Requester tag width
    localparam int ID_BITS = 4;

    // Request of 85 bits
    typedef struct packed {
        logic                     write;
        llc_geom_pkg::line_addr_t addr;
        llc_geom_pkg::line_t      line;
        logic [ID_BITS-1:0]       id;
    } req_t;

    // Memory response of one line
    typedef struct packed {
        llc_geom_pkg::line_t line;
    } mem_rsp_t;

    //##################################################
    // Controller sequence
    //##################################################

    typedef enum logic [2:0] {
        DECODE   = 3'd0,
        READ_SET = 3'd1,
        WAIT     = 3'd2,
        LOOKUP   = 3'd3,
        PROCESS  = 3'd4,
        UPDATE   = 3'd5,
        RESPOND  = 3'd6
    } ctrl_state_e;

endpackage

// ==== hdl/llc_tag_store.sv ====
`timescale 1ns/1ps

module llc_tag_store #(
    parameter int WAYS = llc_geom_pkg::DEF_WAYS,
    parameter int SETS = llc_geom_pkg::DEF_SETS,
    localparam int SET_BITS = $clog2(SETS),
    localparam int TAG_BITS = llc_geom_pkg::ADDR_BITS - SET_BITS,
    localparam int WAY_BITS = $clog2(WAYS)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [SET_BITS-1:0] set_i,
    output logic [TAG_BITS-1:0] tags_o [WAYS],
    output logic [WAYS-1:0]     valid_o,
    output logic [WAYS-1:0]     dirty_o,
    output logic [WAY_BITS-1:0] evict_way_o,
    input  logic [WAY_BITS-1:0] wr_way_i,
    input  logic                wr_en_i,
    input  logic [TAG_BITS-1:0] wr_tag_i,
    input  logic                wr_dirty_i,
    input  logic                adv_evict_i
);

    logic [TAG_BITS-1:0] tag_mem [SETS][WAYS];
    logic [WAYS-1:0]     valid_q [SETS];
    logic [WAYS-1:0]     dirty_q [SETS];
    logic [WAY_BITS-1:0] evict_q [SETS];

    // Tag array
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[set_i][wr_way_i] <= wr_tag_i;
        end
        tags_o <= tag_mem[set_i];
    end

    //##################################################
    // Valid, dirty and evict-way state
    //##################################################

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                evict_q[s] <= '0;
            end
            valid_o     <= '0;
            dirty_o     <= '0;
            evict_way_o <= '0;
        end else begin
            if (wr_en_i) begin
                valid_q[set_i][wr_way_i] <= 1'b1;
                dirty_q[set_i][wr_way_i] <= wr_dirty_i;
            end
            // Round robin over the ways with one step per fill
            if (adv_evict_i) begin
                if (evict_q[set_i] == WAY_BITS'(WAYS - 1)) begin
                    evict_q[set_i] <= '0;
                end else begin
                    evict_q[set_i] <= evict_q[set_i] + 1'b1;
                end
            end
            valid_o     <= valid_q[set_i];
            dirty_o     <= dirty_q[set_i];
            evict_way_o <= evict_q[set_i];
        end
    end

endmodule

// ==== hdl/llc_top.sv ====
`timescale 1ns/1ps

module llc_top #(
    parameter int WAYS = llc_geom_pkg::DEF_WAYS,
    parameter int SETS = llc_geom_pkg::DEF_SETS,
    localparam int SET_BITS = $clog2(SETS),
    localparam int TAG_BITS = llc_geom_pkg::ADDR_BITS - SET_BITS,
    localparam int WAY_BITS = $clog2(WAYS)
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_valid_i,
    output logic                            req_ready_o,
    input  logic                            req_write_i,
    input  llc_geom_pkg::line_addr_t        req_addr_i,
    input  llc_geom_pkg::line_t             req_line_i,
    input  logic [llc_msg_pkg::ID_BITS-1:0] req_id_i,
    output logic                            rsp_valid_o,
    input  logic                            rsp_ready_i,
    output logic [llc_msg_pkg::ID_BITS-1:0] rsp_id_o,
    output llc_geom_pkg::line_t             rsp_line_o,
    output logic                            rsp_hit_o,
    output logic                            mem_req_valid_o,
    input  logic                            mem_req_ready_i,
    output logic                            mem_req_write_o,
    output llc_geom_pkg::line_addr_t        mem_req_addr_o,
    output llc_geom_pkg::line_t             mem_req_line_o,
    input  logic                            mem_rsp_valid_i,
    output logic                            mem_rsp_ready_o,
    input  llc_geom_pkg::line_t             mem_rsp_line_i
);

    llc_msg_pkg::req_t     req_in, req_data;
    llc_msg_pkg::mem_rsp_t mrsp_in, mrsp_data;
    logic                  req_full, req_take;
    logic                  mrsp_full, mrsp_take;

    logic [SET_BITS-1:0]   set;
    logic [TAG_BITS-1:0]   tags [WAYS];
    logic [WAYS-1:0]       way_valid;
    logic [WAYS-1:0]       way_dirty;
    logic [WAY_BITS-1:0]   evict_way;
    llc_geom_pkg::line_t   lines [WAYS];
    logic [WAY_BITS-1:0]   wr_way;
    logic                  tag_wr_en, tag_wr_dirty, adv_evict, line_wr_en;
    logic [TAG_BITS-1:0]   wr_tag;
    llc_geom_pkg::line_t   wr_line;

    // Pack the loose request and memory ports
    assign req_in.write = req_write_i;
    assign req_in.addr  = req_addr_i;
    assign req_in.line  = req_line_i;
    assign req_in.id    = req_id_i;
    assign mrsp_in.line = mem_rsp_line_i;

    llc_chan_buf #(.payload_t(llc_msg_pkg::req_t)) u_req_buf (
        .clk(clk), .rst(rst),
        .valid_i(req_valid_i), .ready_o(req_ready_o), .data_i(req_in),
        .take_i(req_take), .full_o(req_full), .data_o(req_data)
    );

    llc_chan_buf #(.payload_t(llc_msg_pkg::mem_rsp_t)) u_mrsp_buf (
        .clk(clk), .rst(rst),
        .valid_i(mem_rsp_valid_i), .ready_o(mem_rsp_ready_o), .data_i(mrsp_in),
        .take_i(mrsp_take), .full_o(mrsp_full), .data_o(mrsp_data)
    );

    llc_tag_store #(.WAYS(WAYS), .SETS(SETS)) u_tag_store (
        .clk(clk), .rst(rst), .set_i(set),
        .tags_o(tags), .valid_o(way_valid), .dirty_o(way_dirty), .evict_way_o(evict_way),
        .wr_way_i(wr_way), .wr_en_i(tag_wr_en), .wr_tag_i(wr_tag),
        .wr_dirty_i(tag_wr_dirty), .adv_evict_i(adv_evict)
    );

    llc_line_store #(.WAYS(WAYS), .SETS(SETS)) u_line_store (
        .clk(clk), .set_i(set), .lines_o(lines),
        .wr_en_i(line_wr_en), .wr_way_i(wr_way), .wr_line_i(wr_line)
    );

    llc_ctrl #(.WAYS(WAYS), .SETS(SETS)) u_ctrl (
        .clk(clk), .rst(rst),
        .req_full_i(req_full), .req_data_i(req_data), .req_take_o(req_take),
        .mrsp_full_i(mrsp_full), .mrsp_data_i(mrsp_data), .mrsp_take_o(mrsp_take),
        .set_o(set), .tags_i(tags), .way_valid_i(way_valid), .way_dirty_i(way_dirty),
        .evict_way_i(evict_way), .lines_i(lines),
        .wr_way_o(wr_way), .tag_wr_en_o(tag_wr_en), .tag_wr_tag_o(wr_tag),
        .tag_wr_dirty_o(tag_wr_dirty), .adv_evict_o(adv_evict),
        .line_wr_en_o(line_wr_en), .wr_line_o(wr_line),
        .mem_req_valid_o(mem_req_valid_o), .mem_req_ready_i(mem_req_ready_i),
        .mem_req_write_o(mem_req_write_o), .mem_req_addr_o(mem_req_addr_o),
        .mem_req_line_o(mem_req_line_o),
        .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_id_o(rsp_id_o),
        .rsp_line_o(rsp_line_o), .rsp_hit_o(rsp_hit_o)
    );

endmodule

// ==== src.f ====
hdl/llc_geom_pkg.sv
hdl/llc_msg_pkg.sv
hdl/llc_chan_buf.sv
hdl/llc_tag_store.sv
hdl/llc_line_store.sv
hdl/llc_ctrl.sv
hdl/llc_top.sv
tb/llc_tb.sv

// ==== tb/llc_tb.sv ====
`timescale 1ns/1ps

module llc_tb;

    localparam int WAYS     = llc_geom_pkg::DEF_WAYS;
    localparam int SETS     = llc_geom_pkg::DEF_SETS;
    localparam int SET_BITS = $clog2(SETS);
    localparam int LIMIT    = 2000;
    localparam int N_RAND   = 300;

    logic                            clk;
    logic                            rst;
    logic                            req_valid;
    logic                            req_ready;
    logic                            req_write;
    llc_geom_pkg::line_addr_t        req_addr;
    llc_geom_pkg::line_t             req_line;
    logic [llc_msg_pkg::ID_BITS-1:0] req_id;
    logic                            rsp_valid;
    logic                            rsp_ready;
    logic [llc_msg_pkg::ID_BITS-1:0] rsp_id;
    llc_geom_pkg::line_t             rsp_line;
    logic                            rsp_hit;
    logic                            mreq_valid;
    logic                            mreq_ready;
    logic                            mreq_write;
    llc_geom_pkg::line_addr_t        mreq_addr;
    llc_geom_pkg::line_t             mreq_line;
    logic                            mrsp_valid;
    logic                            mrsp_ready;
    llc_geom_pkg::line_t             mrsp_line;

    // Shadow of completed writes, memory contents, pending fill data
    llc_geom_pkg::line_t             shadow [llc_geom_pkg::line_addr_t];
    llc_geom_pkg::line_t             mem [llc_geom_pkg::line_addr_t];
    llc_geom_pkg::line_t             fill_q [$];
    llc_msg_pkg::req_t               exp_q [$];

    int                              value_errors = 0;
    int                              other_errors = 0;
    int                              timeouts = 0;
    int                              sent_cnt = 0;
    int                              rsp_cnt = 0;
    int                              mem_rd_cnt = 0;
    int                              mem_wr_cnt = 0;
    logic                            last_hit;
    llc_geom_pkg::line_addr_t        last_rd_addr;
    llc_geom_pkg::line_addr_t        last_wr_addr;
    llc_geom_pkg::line_t             last_wr_line;
    logic [llc_msg_pkg::ID_BITS-1:0] next_id = '0;
    bit                              random_ready = 1'b0;
    bit                              fill_taken = 1'b0;

    llc_top #(.WAYS(WAYS), .SETS(SETS)) u_dut (
        .clk(clk), .rst(rst),
        .req_valid_i(req_valid), .req_ready_o(req_ready), .req_write_i(req_write),
        .req_addr_i(req_addr), .req_line_i(req_line), .req_id_i(req_id),
        .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready), .rsp_id_o(rsp_id),
        .rsp_line_o(rsp_line), .rsp_hit_o(rsp_hit),
        .mem_req_valid_o(mreq_valid), .mem_req_ready_i(mreq_ready),
        .mem_req_write_o(mreq_write), .mem_req_addr_o(mreq_addr),
        .mem_req_line_o(mreq_line),
        .mem_rsp_valid_i(mrsp_valid), .mem_rsp_ready_o(mrsp_ready),
        .mem_rsp_line_i(mrsp_line)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //##################################################
    // Reference model
    //##################################################

    // Contents of a line that was never written
    function automatic llc_geom_pkg::line_t mem_fill(input llc_geom_pkg::line_addr_t a);
        return {a ^ 16'h3c5a, ~a, a * 16'd7, a + 16'h1001};
    endfunction

    function automatic llc_geom_pkg::line_t expected_line(input llc_geom_pkg::line_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return mem_fill(a);
    endfunction

    function automatic llc_geom_pkg::line_addr_t make_addr(input int tag, input int set_idx);
        return llc_geom_pkg::line_addr_t'((tag << SET_BITS) | set_idx);
    endfunction

    //##################################################
    // Reporting
    //##################################################

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_condition(input bit ok, input string what);
        assert (ok) else begin
            other_errors++;
            $display("ERROR at %0t: %s", $time, what);
        end
    endtask

    task automatic end_run();
        $display("Errors: %0d value, %0d other, %0d timeout",
                 value_errors, other_errors, timeouts);
        if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("TIMEOUT at %0t: %s", $time, what);
        end_run();
    endtask

    //##################################################
    // Memory model and ready drivers
    //##################################################

    always @(posedge clk) begin
        if (rst && mreq_valid && mreq_ready) begin
            if (mreq_write) begin
                mem[mreq_addr] = mreq_line;
                mem_wr_cnt++;
                last_wr_addr = mreq_addr;
                last_wr_line = mreq_line;
            end else begin
                fill_q.push_back(mem.exists(mreq_addr) ? mem[mreq_addr] : mem_fill(mreq_addr));
                mem_rd_cnt++;
                last_rd_addr = mreq_addr;
            end
        end
        if (rst && mrsp_valid && mrsp_ready) begin
            void'(fill_q.pop_front());
            fill_taken = 1'b1;
        end
    end

    task automatic drive_ready_and_fill();
        forever begin
            @(negedge clk);
            mreq_ready = ($urandom_range(0, 3) != 0);
            if (random_ready) begin
                rsp_ready = ($urandom_range(0, 3) != 0);
            end else begin
                rsp_ready = 1'b1;
            end
            if (fill_taken) begin
                mrsp_valid = 1'b0;
                fill_taken = 1'b0;
            end
            // Fill data after a random delay
            if (!mrsp_valid && fill_q.size() > 0 && $urandom_range(0, 2) == 0) begin
                mrsp_valid = 1'b1;
                mrsp_line  = fill_q[0];
            end
        end
    endtask

    //##################################################
    // Comparing process
    //##################################################

    always @(posedge clk) begin
        llc_msg_pkg::req_t exp_req;
        if (rst && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                check_condition(1'b0, "response arrived with no request outstanding");
            end else begin
                exp_req = exp_q.pop_front();
                if (exp_req.write) begin
                    shadow[exp_req.addr] = exp_req.line;
                end
                compare_value("rsp_id_o", 64'(rsp_id), 64'(exp_req.id));
                compare_value("rsp_line_o", rsp_line, expected_line(exp_req.addr));
            end
            last_hit = rsp_hit;
            rsp_cnt++;
        end
        if (rst && mreq_valid && mreq_ready && mreq_write) begin
            compare_value("mem_req_line_o", mreq_line, expected_line(mreq_addr));
        end
    end

    //##################################################
    // Stimulus
    //##################################################

    task automatic send_request(input logic wr, input llc_geom_pkg::line_addr_t a,
                                input llc_geom_pkg::line_t line);
        llc_msg_pkg::req_t r;
        int waited;
        r.write = wr;
        r.addr  = a;
        r.line  = line;
        r.id    = next_id;
        @(negedge clk);
        exp_q.push_back(r);
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = a;
        req_line  = line;
        req_id    = next_id;
        waited = 0;
        while (!req_ready && waited < LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            report_timeout("request channel never became ready");
        end
        @(negedge clk);
        req_valid = 1'b0;
        next_id++;
        sent_cnt++;
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (rsp_cnt != sent_cnt && waited < LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rsp_cnt != sent_cnt) begin
            report_timeout("responses still missing");
        end
    endtask

    initial begin
        llc_geom_pkg::line_addr_t first_addr;
        llc_geom_pkg::line_t      first_line;
        llc_geom_pkg::line_addr_t a;
        logic                     wr;
        int                       rd0;
        int                       wr0;
        rst        = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_line   = '0;
        req_id     = '0;
        rsp_ready  = 1'b0;
        mreq_ready = 1'b0;
        mrsp_valid = 1'b0;
        mrsp_line  = '0;
        void'($urandom(34744));
        fork
            drive_ready_and_fill();
        join_none
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // Read of a never-written line
        a   = make_addr(5, 1);
        rd0 = mem_rd_cnt;
        wr0 = mem_wr_cnt;
        send_request(1'b0, a, '0);
        wait_responses();
        compare_value("rsp_hit_o", 64'(last_hit), 64'(1'b0));
        check_condition(mem_rd_cnt == rd0 + 1 && last_rd_addr == a,
                        "first read did not make exactly one memory read of its line");
        check_condition(mem_wr_cnt == wr0, "first read wrote to memory");

        // Write, then read back
        a = make_addr(3, 2);
        send_request(1'b1, a, 64'h0123_4567_89ab_cdef);
        wait_responses();
        rd0 = mem_rd_cnt;
        wr0 = mem_wr_cnt;
        send_request(1'b0, a, '0);
        wait_responses();
        compare_value("rsp_hit_o", 64'(last_hit), 64'(1'b1));
        check_condition(mem_rd_cnt == rd0 && mem_wr_cnt == wr0, "read hit reached memory");

        // Dirty eviction in a fresh set
        first_addr = make_addr(1, 3);
        first_line = {$urandom, $urandom};
        send_request(1'b1, first_addr, first_line);
        wait_responses();
        for (int k = 2; k <= WAYS; k++) begin
            send_request(1'b1, make_addr(k, 3), {$urandom, $urandom});
            wait_responses();
        end
        wr0 = mem_wr_cnt;
        send_request(1'b1, make_addr(WAYS + 1, 3), {$urandom, $urandom});
        wait_responses();
        check_condition(mem_wr_cnt == wr0 + 1, "eviction did not make one memory write");
        compare_value("mem_req_addr_o", 64'(last_wr_addr), 64'(first_addr));
        compare_value("mem_req_line_o", last_wr_line, first_line);
        send_request(1'b0, first_addr, '0);
        wait_responses();
        compare_value("rsp_hit_o", 64'(last_hit), 64'(1'b0));

        // Clean eviction in a fresh set
        wr0 = mem_wr_cnt;
        for (int k = 1; k <= WAYS + 1; k++) begin
            send_request(1'b0, make_addr(k, 4), '0);
            wait_responses();
        end
        check_condition(mem_wr_cnt == wr0, "clean eviction wrote to memory");

        // Mixed traffic over two sets with back-pressure
        random_ready = 1'b1;
        for (int n = 0; n < N_RAND; n++) begin
            wr = 1'($urandom_range(0, 1));
            a  = make_addr($urandom_range(0, 5), $urandom_range(0, 1));
            send_request(wr, a, {$urandom, $urandom});
        end
        wait_responses();
        random_ready = 1'b0;
        end_run();
    end

endmodule
